// File: Makefile
# Verilator flow for the FALU

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f falu.f --top-module falu_top

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f falu.f \
		--top-module falu_tb -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/falu_classify.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU operand classifier
// Sorts one single-precision word into its IEEE categories
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_classify (
  input  falu_pkg::fp_word_u opnd,
  output logic               is_zero,
  output logic               is_subnorm,
  output logic               is_norm,
  output logic               is_inf,
  output logic               is_snan,
  output logic               is_qnan
);

  logic exp_zero;
  logic exp_ones;
  logic frac_zero;
  logic frac_msb;

  assign exp_zero  = ~|opnd.fields.exponent;
  assign exp_ones  = &opnd.fields.exponent;
  assign frac_zero = ~|opnd.fields.fraction;
  assign frac_msb  = opnd.fields.fraction[`FALU_FRAC_W-1];

  assign is_zero    = exp_zero & frac_zero;
  assign is_subnorm = exp_zero & ~frac_zero;
  assign is_norm    = ~exp_zero & ~exp_ones;
  assign is_inf     = exp_ones & frac_zero;

  // Quiet bit is the top fraction bit
  assign is_qnan = exp_ones & frac_msb;
  assign is_snan = exp_ones & ~frac_zero & ~frac_msb;

endmodule

// File: design/falu_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU execution stage
// Sign injection, min/max, compares, class and moves
// Result and flags are held in one output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_exec (
  input  logic                     forever_cpuclk,
  input  logic                     reset,
  input  logic                     inst_vld,
  input  logic [`FALU_FUNC_W-1:0]  inst_func,
  input  logic [`FALU_REG_W-1:0]   inst_dst_reg,
  input  falu_pkg::fp_word_u       inst_srcf0,
  input  falu_pkg::fp_word_u       inst_srcf1,
  input  logic [`FALU_XLEN-1:0]    inst_srci,
  output logic                     inst_ready,
  output logic                     ex_vld,
  output falu_pkg::fp_word_u       ex_data,
  output logic [`FALU_REG_W-1:0]   ex_reg,
  output logic                     ex_wb_gpr,
  output logic [`FALU_FFLAG_W-1:0] ex_fflags,
  input  logic                     ex_ready
);

  import falu_pkg::*;

  localparam int CLASS_W = 10;

  logic               zero0, subn0, norm0, inf0, snan0, qnan0;
  logic               zero1, snan1, qnan1;
  logic               sign0, sign1;
  logic               nan0, nan1;
  logic               any_nan, any_snan;
  logic               mag_lt, mag_eq, ord_lt, both_zero;
  logic               feq, flt, fle;
  logic               is_max;
  logic [CLASS_W-1:0] class_mask;
  fp_word_u           minmax_res;
  fp_word_u           res_data;
  logic               res_nv;
  logic               res_gpr;
  logic               load;

  falu_classify u_class0 (
    .opnd       (inst_srcf0),
    .is_zero    (zero0),
    .is_subnorm (subn0),
    .is_norm    (norm0),
    .is_inf     (inf0),
    .is_snan    (snan0),
    .is_qnan    (qnan0)
  );

  falu_classify u_class1 (
    .opnd       (inst_srcf1),
    .is_zero    (zero1),
    .is_subnorm (),
    .is_norm    (),
    .is_inf     (),
    .is_snan    (snan1),
    .is_qnan    (qnan1)
  );

  assign sign0    = inst_srcf0.fields.sign;
  assign sign1    = inst_srcf1.fields.sign;
  assign nan0     = snan0 | qnan0;
  assign nan1     = snan1 | qnan1;
  assign any_nan  = nan0 | nan1;
  assign any_snan = snan0 | snan1;

  // Magnitudes order like unsigned integers once the sign is removed
  assign mag_lt = inst_srcf0.bits[`FALU_XLEN-2:0] < inst_srcf1.bits[`FALU_XLEN-2:0];
  assign mag_eq = inst_srcf0.bits[`FALU_XLEN-2:0] == inst_srcf1.bits[`FALU_XLEN-2:0];

  // Total order with -0 below +0
  assign ord_lt = (sign0 & ~sign1) | (~sign0 & ~sign1 & mag_lt) |
                  (sign0 & sign1 & ~mag_lt & ~mag_eq);

  // Compares treat the two zeros as equal
  assign both_zero = zero0 & zero1;
  assign feq = ~any_nan & ((inst_srcf0.bits == inst_srcf1.bits) | both_zero);
  assign flt = ~any_nan & ~both_zero & ord_lt;
  assign fle = flt | feq;

  assign class_mask = {qnan0, snan0,
                       ~sign0 & inf0, ~sign0 & norm0, ~sign0 & subn0, ~sign0 & zero0,
                       sign0 & zero0, sign0 & subn0, sign0 & norm0, sign0 & inf0};

  assign is_max = (inst_func == `FALU_OP_FMAX);

  always_comb begin
    if (nan0 & nan1) begin
      minmax_res.bits = `FALU_CANON_NAN;
    end else if (nan0) begin
      minmax_res = inst_srcf1;
    end else if (nan1) begin
      minmax_res = inst_srcf0;
    end else if (ord_lt ^ is_max) begin
      minmax_res = inst_srcf0;
    end else begin
      minmax_res = inst_srcf1;
    end
  end

  always_comb begin
    // FSGNJ unless decoded otherwise
    res_data             = inst_srcf0;
    res_data.fields.sign = sign1;
    res_nv               = 1'b0;
    res_gpr              = 1'b0;
    case (inst_func)
      `FALU_OP_FSGNJN: res_data.fields.sign = ~sign1;
      `FALU_OP_FSGNJX: res_data.fields.sign = sign0 ^ sign1;
      `FALU_OP_FMIN, `FALU_OP_FMAX: begin
        res_data = minmax_res;
        res_nv   = any_snan;
      end
      `FALU_OP_FEQ: begin
        res_data.bits = {{(`FALU_XLEN-1){1'b0}}, feq};
        res_nv        = any_snan;
        res_gpr       = 1'b1;
      end
      `FALU_OP_FLT: begin
        res_data.bits = {{(`FALU_XLEN-1){1'b0}}, flt};
        res_nv        = any_nan;
        res_gpr       = 1'b1;
      end
      `FALU_OP_FLE: begin
        res_data.bits = {{(`FALU_XLEN-1){1'b0}}, fle};
        res_nv        = any_nan;
        res_gpr       = 1'b1;
      end
      `FALU_OP_FCLASS: begin
        res_data.bits = {{(`FALU_XLEN-CLASS_W){1'b0}}, class_mask};
        res_gpr       = 1'b1;
      end
      `FALU_OP_FMV_X_W: begin
        res_data = inst_srcf0;
        res_gpr  = 1'b1;
      end
      `FALU_OP_FMV_W_X: res_data.bits = inst_srci;
      default: ;
    endcase
  end

  // Output register takes a new result when empty or draining
  assign load       = ~ex_vld | ex_ready;
  assign inst_ready = load;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ex_vld <= 1'b0;
    end else if (load) begin
      ex_vld <= inst_vld;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (load & inst_vld) begin
      ex_data   <= res_data;
      ex_reg    <= inst_dst_reg;
      ex_wb_gpr <= res_gpr;
      ex_fflags <= {res_nv, {(`FALU_FFLAG_W-1){1'b0}}};
    end
  end

endmodule

// File: design/falu_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU constants
// Word layout, queue depth and operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FALU_PARAMS_SVH
`define FALU_PARAMS_SVH

`define FALU_XLEN        32
`define FALU_EXP_W       8
`define FALU_FRAC_W      23
`define FALU_REG_W       5
`define FALU_FUNC_W      4
// Only NV (bit 4) is ever raised
`define FALU_FFLAG_W     5
`define FALU_FIFO_DEPTH  4

`define FALU_OP_FSGNJ    4'd0
`define FALU_OP_FSGNJN   4'd1
`define FALU_OP_FSGNJX   4'd2
`define FALU_OP_FMIN     4'd3
`define FALU_OP_FMAX     4'd4
`define FALU_OP_FEQ      4'd5
`define FALU_OP_FLT      4'd6
`define FALU_OP_FLE      4'd7
`define FALU_OP_FCLASS   4'd8
`define FALU_OP_FMV_X_W  4'd9
`define FALU_OP_FMV_W_X  4'd10

`define FALU_CANON_NAN   32'h7fc00000

`endif

// File: design/falu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU types
// Single-precision word seen as raw bits or as IEEE fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "falu_params.svh"

package falu_pkg;

  typedef struct packed {
    logic                    sign;
    logic [`FALU_EXP_W-1:0]  exponent;
    logic [`FALU_FRAC_W-1:0] fraction;
  } fp_fields_t;

  // Raw view for moves and magnitude order, field view for classification
  typedef union packed {
    logic [`FALU_XLEN-1:0] bits;
    fp_fields_t            fields;
  } fp_word_u;

endpackage

// File: design/falu_result_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU result queue
// Keeps finished results in issue order until writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_result_fifo #(
  parameter int DEPTH = `FALU_FIFO_DEPTH
) (
  input  logic                     forever_cpuclk,
  input  logic                     reset,
  input  logic                     ex_vld,
  input  falu_pkg::fp_word_u       ex_data,
  input  logic [`FALU_REG_W-1:0]   ex_reg,
  input  logic                     ex_wb_gpr,
  input  logic [`FALU_FFLAG_W-1:0] ex_fflags,
  output logic                     ex_ready,
  output logic                     hd_vld,
  output falu_pkg::fp_word_u       hd_data,
  output logic [`FALU_REG_W-1:0]   hd_reg,
  output logic                     hd_wb_gpr,
  output logic [`FALU_FFLAG_W-1:0] hd_fflags,
  input  logic                     hd_pop
);

  import falu_pkg::*;

  localparam int AW = $clog2(DEPTH);

  fp_word_u                 mem_data   [DEPTH];
  logic [`FALU_REG_W-1:0]   mem_reg    [DEPTH];
  logic                     mem_gpr    [DEPTH];
  logic [`FALU_FFLAG_W-1:0] mem_fflags [DEPTH];
  logic [AW-1:0]            wr_ptr, rd_ptr;
  logic [AW:0]              count;
  logic                     full;
  logic                     push;

  // Depth is a power of two, so the top count bit means full
  assign full     = count[AW];
  assign ex_ready = ~full | hd_pop;
  assign push     = ex_vld & ex_ready;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (hd_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, hd_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (push) begin
      mem_data[wr_ptr]   <= ex_data;
      mem_reg[wr_ptr]    <= ex_reg;
      mem_gpr[wr_ptr]    <= ex_wb_gpr;
      mem_fflags[wr_ptr] <= ex_fflags;
    end
  end

  assign hd_vld    = (count != '0);
  assign hd_data   = mem_data[rd_ptr];
  assign hd_reg    = mem_reg[rd_ptr];
  assign hd_wb_gpr = mem_gpr[rd_ptr];
  assign hd_fflags = mem_fflags[rd_ptr];

endmodule

// File: design/falu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU top
// Execution stage, result queue and writeback bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_top (
  input  logic                     forever_cpuclk,
  input  logic                     reset,
  input  logic                     inst_vld,
  input  logic [`FALU_FUNC_W-1:0]  inst_func,
  input  logic [`FALU_REG_W-1:0]   inst_dst_reg,
  input  falu_pkg::fp_word_u       inst_srcf0,
  input  falu_pkg::fp_word_u       inst_srcf1,
  input  logic [`FALU_XLEN-1:0]    inst_srci,
  output logic                     inst_ready,
  output logic                     fgpr_wb_vld,
  output logic [`FALU_REG_W-1:0]   fgpr_wb_reg,
  output logic [`FALU_XLEN-1:0]    fgpr_wb_data,
  input  logic                     fgpr_wb_grant,
  output logic                     wb_vld,
  output logic [`FALU_REG_W-1:0]   wb_preg,
  output logic [`FALU_XLEN-1:0]    wb_data,
  input  logic                     wb_grant,
  output logic [`FALU_FFLAG_W-1:0] wb_fflags,
  output logic                     wb_fflags_updt
);

  import falu_pkg::*;

  logic                     ex_vld;
  fp_word_u                 ex_data;
  logic [`FALU_REG_W-1:0]   ex_reg;
  logic                     ex_wb_gpr;
  logic [`FALU_FFLAG_W-1:0] ex_fflags;
  logic                     ex_ready;
  logic                     hd_vld;
  fp_word_u                 hd_data;
  logic [`FALU_REG_W-1:0]   hd_reg;
  logic                     hd_wb_gpr;
  logic [`FALU_FFLAG_W-1:0] hd_fflags;
  logic                     hd_pop;

  falu_exec u_exec (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .inst_vld       (inst_vld),
    .inst_func      (inst_func),
    .inst_dst_reg   (inst_dst_reg),
    .inst_srcf0     (inst_srcf0),
    .inst_srcf1     (inst_srcf1),
    .inst_srci      (inst_srci),
    .inst_ready     (inst_ready),
    .ex_vld         (ex_vld),
    .ex_data        (ex_data),
    .ex_reg         (ex_reg),
    .ex_wb_gpr      (ex_wb_gpr),
    .ex_fflags      (ex_fflags),
    .ex_ready       (ex_ready)
  );

  falu_result_fifo #(
    .DEPTH (`FALU_FIFO_DEPTH)
  ) u_fifo (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .ex_vld         (ex_vld),
    .ex_data        (ex_data),
    .ex_reg         (ex_reg),
    .ex_wb_gpr      (ex_wb_gpr),
    .ex_fflags      (ex_fflags),
    .ex_ready       (ex_ready),
    .hd_vld         (hd_vld),
    .hd_data        (hd_data),
    .hd_reg         (hd_reg),
    .hd_wb_gpr      (hd_wb_gpr),
    .hd_fflags      (hd_fflags),
    .hd_pop         (hd_pop)
  );

  falu_wb_bus u_wb_bus (
    .hd_vld         (hd_vld),
    .hd_data        (hd_data),
    .hd_reg         (hd_reg),
    .hd_wb_gpr      (hd_wb_gpr),
    .hd_fflags      (hd_fflags),
    .hd_pop         (hd_pop),
    .fgpr_wb_vld    (fgpr_wb_vld),
    .fgpr_wb_reg    (fgpr_wb_reg),
    .fgpr_wb_data   (fgpr_wb_data),
    .fgpr_wb_grant  (fgpr_wb_grant),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data),
    .wb_grant       (wb_grant),
    .wb_fflags      (wb_fflags),
    .wb_fflags_updt (wb_fflags_updt)
  );

endmodule

// File: design/falu_wb_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU writeback bus
// Steers the queue head to the float or integer port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_wb_bus (
  input  logic                     hd_vld,
  input  falu_pkg::fp_word_u       hd_data,
  input  logic [`FALU_REG_W-1:0]   hd_reg,
  input  logic                     hd_wb_gpr,
  input  logic [`FALU_FFLAG_W-1:0] hd_fflags,
  output logic                     hd_pop,
  output logic                     fgpr_wb_vld,
  output logic [`FALU_REG_W-1:0]   fgpr_wb_reg,
  output logic [`FALU_XLEN-1:0]    fgpr_wb_data,
  input  logic                     fgpr_wb_grant,
  output logic                     wb_vld,
  output logic [`FALU_REG_W-1:0]   wb_preg,
  output logic [`FALU_XLEN-1:0]    wb_data,
  input  logic                     wb_grant,
  output logic [`FALU_FFLAG_W-1:0] wb_fflags,
  output logic                     wb_fflags_updt
);

  // Exactly one port sees the head
  assign fgpr_wb_vld  = hd_vld & ~hd_wb_gpr;
  assign wb_vld       = hd_vld & hd_wb_gpr;

  assign fgpr_wb_reg  = hd_reg;
  assign fgpr_wb_data = hd_data.bits;
  assign wb_preg      = hd_reg;
  assign wb_data      = hd_data.bits;

  // Pop on the grant of whichever port is requesting
  assign hd_pop = (fgpr_wb_vld & fgpr_wb_grant) | (wb_vld & wb_grant);

  assign wb_fflags_updt = hd_pop;
  assign wb_fflags      = hd_pop ? hd_fflags : '0;

endmodule

// File: falu.f
+incdir+design
design/falu_pkg.sv
design/falu_classify.sv
design/falu_exec.sv
design/falu_result_fifo.sv
design/falu_wb_bus.sv
design/falu_top.sv
sim/falu_tb.sv

// File: sim/falu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FALU testbench
// Random issue under grant back-pressure, checked
// against a reference model at the writeback ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "falu_params.svh"

module falu_tb;

  localparam int NUM_INSTS  = 400;
  // 400 issues, each well under 50 cycles even in long stall phases
  localparam int MAX_CYCLES = 20000;

  typedef struct packed {
    logic [`FALU_FUNC_W-1:0]  op;
    logic                     gpr;
    logic [`FALU_REG_W-1:0]   rd;
    logic [`FALU_XLEN-1:0]    data;
    logic [`FALU_FFLAG_W-1:0] flags;
  } exp_t;

  logic                     forever_cpuclk;
  logic                     reset;
  logic                     inst_vld;
  logic [`FALU_FUNC_W-1:0]  inst_func;
  logic [`FALU_REG_W-1:0]   inst_dst_reg;
  logic [`FALU_XLEN-1:0]    inst_srcf0;
  logic [`FALU_XLEN-1:0]    inst_srcf1;
  logic [`FALU_XLEN-1:0]    inst_srci;
  logic                     inst_ready;
  logic                     fgpr_wb_vld;
  logic [`FALU_REG_W-1:0]   fgpr_wb_reg;
  logic [`FALU_XLEN-1:0]    fgpr_wb_data;
  logic                     fgpr_wb_grant;
  logic                     wb_vld;
  logic [`FALU_REG_W-1:0]   wb_preg;
  logic [`FALU_XLEN-1:0]    wb_data;
  logic                     wb_grant;
  logic [`FALU_FFLAG_W-1:0] wb_fflags;
  logic                     wb_fflags_updt;

  exp_t                     exp_q[$];
  exp_t                     head;
  int                       value_errs;
  int                       other_errs;
  int                       accepted;
  int                       sent;
  int                       cycle_cnt;
  int                       phase_left;
  int                       seed_ret;
  logic [1:0]               grant_mode;
  logic                     took;
  logic                     xfer;
  logic                     full_seen;
  logic                     held;
  logic                     held_gpr;
  logic [`FALU_REG_W-1:0]   held_reg;
  logic [`FALU_XLEN-1:0]    held_data;
  logic [`FALU_REG_W-1:0]   act_reg;
  logic [`FALU_XLEN-1:0]    act_data;

  falu_top u_dut (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .inst_vld       (inst_vld),
    .inst_func      (inst_func),
    .inst_dst_reg   (inst_dst_reg),
    .inst_srcf0     (inst_srcf0),
    .inst_srcf1     (inst_srcf1),
    .inst_srci      (inst_srci),
    .inst_ready     (inst_ready),
    .fgpr_wb_vld    (fgpr_wb_vld),
    .fgpr_wb_reg    (fgpr_wb_reg),
    .fgpr_wb_data   (fgpr_wb_data),
    .fgpr_wb_grant  (fgpr_wb_grant),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data),
    .wb_grant       (wb_grant),
    .wb_fflags      (wb_fflags),
    .wb_fflags_updt (wb_fflags_updt)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #50 forever_cpuclk = ~forever_cpuclk;
    end
  end

  function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] w);
    return is_nan(w) && !w[22];
  endfunction

  // Signed integer key where both zeros map to 0
  function automatic longint order_key(input logic [31:0] w);
    longint mag;
    mag = longint'({33'd0, w[30:0]});
    return w[31] ? -mag : mag;
  endfunction

  function automatic int class_index(input logic [31:0] w);
    if (is_nan(w)) return w[22] ? 9 : 8;
    if (w[30:23] == 8'hff) return w[31] ? 0 : 7;
    if (w[30:0] == 31'd0) return w[31] ? 3 : 4;
    if (w[30:23] == 8'h00) return w[31] ? 2 : 5;
    return w[31] ? 1 : 6;
  endfunction

  function automatic exp_t predict(input logic [3:0] op, input logic [4:0] rd,
                                   input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] x);
    exp_t e;
    logic any_nan;
    logic any_snan;
    logic lt;
    logic eq;
    logic a_below;
    any_nan  = is_nan(a) || is_nan(b);
    any_snan = is_snan(a) || is_snan(b);
    lt       = order_key(a) < order_key(b);
    eq       = order_key(a) == order_key(b);
    // -0 sits below +0 for min and max only
    a_below  = lt || (eq && a[31] && !b[31]);
    e.op     = op;
    e.rd     = rd;
    e.gpr    = 1'b0;
    e.flags  = '0;
    e.data   = {b[31], a[30:0]};
    case (op)
      `FALU_OP_FSGNJN: e.data = {~b[31], a[30:0]};
      `FALU_OP_FSGNJX: e.data = {a[31] ^ b[31], a[30:0]};
      `FALU_OP_FMIN, `FALU_OP_FMAX: begin
        if (is_nan(a) && is_nan(b)) e.data = `FALU_CANON_NAN;
        else if (is_nan(a)) e.data = b;
        else if (is_nan(b)) e.data = a;
        else if (op == `FALU_OP_FMIN) e.data = a_below ? a : b;
        else e.data = a_below ? b : a;
        e.flags[4] = any_snan;
      end
      `FALU_OP_FEQ, `FALU_OP_FLT, `FALU_OP_FLE: begin
        e.gpr = 1'b1;
        if (op == `FALU_OP_FEQ) e.data = {31'd0, !any_nan && eq};
        else if (op == `FALU_OP_FLT) e.data = {31'd0, !any_nan && lt};
        else e.data = {31'd0, !any_nan && (lt || eq)};
        e.flags[4] = (op == `FALU_OP_FEQ) ? any_snan : any_nan;
      end
      `FALU_OP_FCLASS: begin
        e.gpr  = 1'b1;
        e.data = 32'd1 << class_index(a);
      end
      `FALU_OP_FMV_X_W: begin
        e.gpr  = 1'b1;
        e.data = a;
      end
      `FALU_OP_FMV_W_X: e.data = x;
      default: ;
    endcase
    return e;
  endfunction

  // Operand pool over all IEEE categories plus raw words
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    logic [31:0] f;
    logic [7:0]  ex;
    r  = $urandom;
    f  = $urandom;
    ex = f[30:23];
    if (ex == 8'h00) ex = 8'h01;
    if (ex == 8'hff) ex = 8'hfe;
    case (r[2:0])
      3'd0:    return {r[31], 31'd0};
      3'd1:    return {r[31], 8'h00, f[22:1], 1'b1};
      3'd2:    return {r[31], ex, f[22:0]};
      3'd3:    return {r[31], 8'hff, 23'd0};
      3'd4:    return {r[31], 8'hff, 1'b0, f[21:1], 1'b1};
      3'd5:    return {r[31], 8'hff, 1'b1, f[21:0]};
      default: return f;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] actv);
    assert (expv == actv) else begin
      value_errs++;
      $display("error %0t %s expected %h got %h", $time, name, expv, actv);
    end
  endtask

  // Phases of stalled, random or open grants
  task automatic drive_grants();
    logic [31:0] r;
    r = $urandom;
    if (phase_left == 0) begin
      grant_mode = r[1:0];
      phase_left = 10 + int'(r[7:2]);
    end else begin
      phase_left--;
    end
    fgpr_wb_grant = (grant_mode == 2'd3) || (grant_mode != 2'd0 && r[8]);
    wb_grant      = (grant_mode == 2'd3) || (grant_mode != 2'd0 && r[9]);
  endtask

  task automatic drive_instruction();
    logic [31:0] r;
    r            = $urandom;
    inst_func    = r[3:0];
    inst_dst_reg = r[8:4];
    inst_srcf0   = pick_operand();
    inst_srcf1   = pick_operand();
    if (r[12:10] == 3'd0) inst_srcf1 = inst_srcf0;
    inst_srci    = $urandom;
    inst_vld     = 1'b1;
  endtask

  always @(negedge forever_cpuclk) begin
    if (!reset) begin
      xfer     = (fgpr_wb_vld & fgpr_wb_grant) | (wb_vld & wb_grant);
      act_reg  = wb_vld ? wb_preg : fgpr_wb_reg;
      act_data = wb_vld ? wb_data : fgpr_wb_data;
      assert (!(fgpr_wb_vld && wb_vld)) else begin
        other_errs++;
        $display("both writeback ports valid at %0t", $time);
      end
      check_value("wb_fflags_updt", 32'(xfer), 32'(wb_fflags_updt));
      if (held) begin
        assert (wb_vld == held_gpr && fgpr_wb_vld != held_gpr &&
                act_reg == held_reg && act_data == held_data) else begin
          other_errs++;
          $display("writeback changed at %0t while waiting for its grant", $time);
        end
      end
      if (fgpr_wb_vld || wb_vld) begin
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("writeback at %0t with no instruction outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          head = exp_q[0];
          check_value("wb_vld", 32'(head.gpr), 32'(wb_vld));
          if (head.gpr) begin
            check_value("wb_preg", 32'(head.rd), 32'(wb_preg));
            check_value("wb_data", head.data, wb_data);
          end else begin
            check_value("fgpr_wb_reg", 32'(head.rd), 32'(fgpr_wb_reg));
            check_value("fgpr_wb_data", head.data, fgpr_wb_data);
          end
          if (head.op == `FALU_OP_FCLASS) begin
            assert ($onehot(wb_data[9:0]) && wb_data[31:10] == 22'd0) else begin
              other_errs++;
              $display("FCLASS result at %0t is not a single mask bit", $time);
            end
          end
          if (xfer) begin
            check_value("wb_fflags", 32'(head.flags), 32'(wb_fflags));
            head = exp_q.pop_front();
          end
        end
      end
      held      = (fgpr_wb_vld || wb_vld) && !xfer;
      held_gpr  = wb_vld;
      held_reg  = act_reg;
      held_data = act_data;
      if (inst_vld && inst_ready) begin
        exp_q.push_back(predict(inst_func, inst_dst_reg, inst_srcf0, inst_srcf1, inst_srci));
      end
      assert (exp_q.size() <= `FALU_FIFO_DEPTH + 1) else begin
        other_errs++;
        $display("more than queue depth plus one results in flight at %0t", $time);
      end
      if (exp_q.size() == `FALU_FIFO_DEPTH + 1) full_seen = 1'b1;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge forever_cpuclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d results still outstanding",
             cycle_cnt, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed_ret      = $urandom(32'h69026f51);
    reset         = 1'b1;
    inst_vld      = 1'b0;
    inst_func     = '0;
    inst_dst_reg  = '0;
    inst_srcf0    = '0;
    inst_srcf1    = '0;
    inst_srci     = '0;
    fgpr_wb_grant = 1'b0;
    wb_grant      = 1'b0;
    value_errs    = 0;
    other_errs    = 0;
    accepted      = 0;
    sent          = 0;
    phase_left    = 0;
    grant_mode    = 2'd0;
    full_seen     = 1'b0;
    held          = 1'b0;
    repeat (3) @(posedge forever_cpuclk);
    #10 reset = 1'b0;
    @(negedge forever_cpuclk);
    assert (inst_ready && !fgpr_wb_vld && !wb_vld && !wb_fflags_updt) else begin
      other_errs++;
      $display("outputs not idle after reset");
    end
    while (accepted < NUM_INSTS || exp_q.size() != 0) begin
      @(negedge forever_cpuclk);
      took = inst_vld && inst_ready;
      @(posedge forever_cpuclk);
      #10;
      drive_grants();
      if (took) begin
        accepted++;
        inst_vld = 1'b0;
      end
      if (!inst_vld && sent < NUM_INSTS && ($urandom % 8) != 0) begin
        drive_instruction();
        sent++;
      end
    end
    assert (full_seen) else begin
      other_errs++;
      $display("back-pressure never filled the queue and the exec stage");
    end
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
